//--- bench/ppu_tb.sv
`timescale 1ns/1ps

`include "ppu_settings.svh"

module ppu_tb;

  localparam int unsigned FRAME     = `PPU_CYCLES_PER_LINE * `PPU_LINES_PER_FRAME;
  localparam logic [15:0] LCDC_ADDR = 16'hFF40;
  localparam logic [15:0] STAT_ADDR = 16'hFF41;
  localparam logic [15:0] LY_ADDR   = 16'hFF44;
  localparam logic [15:0] LYC_ADDR  = 16'hFF45;

  logic              clk;
  logic              reset;
  ppu_pkg::ppu_bus_t bus;
  logic [7:0]        rdata;
  ppu_pkg::ppu_irq_t irq;

  int unsigned cyc        = 0;
  int unsigned start_cyc  = 0;
  logic        track_on   = 1'b0;
  logic [7:0]  lyc_shadow = 8'h00;
  integer      seed       = 32'h5175a059;

  ppu_top i_dut (.clk(clk), .reset(reset), .bus(bus), .rdata(rdata), .irq(irq));

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  always @(posedge clk) cyc <= cyc + 1;

  // ============================================================
  // Reference model and checks
  // ============================================================
  // Expected mode and LY, p cycles after counting starts
  function automatic ppu_pkg::ppu_timing_t ref_timing(input int unsigned p);
    int unsigned dot;
    int unsigned line;
    ppu_pkg::ppu_timing_t t;
    dot  = p % `PPU_CYCLES_PER_LINE;
    line = (p / `PPU_CYCLES_PER_LINE) % `PPU_LINES_PER_FRAME;
    t.ly = 8'(line);
    if (line >= `PPU_VISIBLE_LINES) t.mode = ppu_pkg::VBLANK;
    else if (dot < `PPU_MODE2_LEN) t.mode = ppu_pkg::OAM_SCAN;
    else if (dot < `PPU_MODE2_LEN + `PPU_MODE3_LEN) t.mode = ppu_pkg::TRANSFER;
    else t.mode = ppu_pkg::HBLANK;
    return t;
  endfunction

  task automatic abort_run;
    $display("Testbench failed");
    $fatal(1, "Simulation stopped at first error");
  endtask

  task automatic check_value(input string name, input logic [7:0] expected,
                             input logic [7:0] actual);
    if (expected !== actual) begin
      $display("FAIL %s expected 0x%02h actual 0x%02h", name, expected, actual);
      abort_run();
    end
  endtask

  // Every STAT or LY read is held against the model while tracking
  always @(negedge clk) begin
    ppu_pkg::ppu_timing_t exp_t;
    exp_t = ref_timing(cyc - start_cyc);
    if (track_on && bus.read_en && bus.addr == STAT_ADDR) begin
      check_value("stat_mode", {6'd0, exp_t.mode}, {6'd0, rdata[1:0]});
      check_value("stat_lyc_flag", {7'd0, exp_t.ly == lyc_shadow}, {7'd0, rdata[2]});
    end else if (track_on && bus.read_en && bus.addr == LY_ADDR) begin
      check_value("ly", exp_t.ly, rdata);
    end
  end

  // ============================================================
  // Bus helpers
  // ============================================================
  task automatic next_cycle;
    @(posedge clk);
    #1;
  endtask

  task automatic write_bus(input logic [15:0] addr, input logic [7:0] data);
    next_cycle();
    bus = '{read_en: 1'b0, write_en: 1'b1, addr: addr, wdata: data};
    next_cycle();
    bus.write_en = 1'b0;
    if (addr == LYC_ADDR) lyc_shadow = data;
  endtask

  task automatic read_bus(input logic [15:0] addr, output logic [7:0] data);
    next_cycle();
    bus = '{read_en: 1'b1, write_en: 1'b0, addr: addr, wdata: 8'h00};
    @(negedge clk);
    data = rdata;
  endtask

  task automatic wait_for_mode(input logic [1:0] mode);
    logic [7:0] stat;
    int unsigned n = 0;
    read_bus(STAT_ADDR, stat);
    while (stat[1:0] != mode) begin
      n++;
      if (n > FRAME) begin
        $display("Timeout waiting for display mode %0d", mode);
        abort_run();
      end
      read_bus(STAT_ADDR, stat);
    end
  endtask

  // One frame of reads at addr, VBlank checked and STAT requests counted
  task automatic frame_pulses(input logic [15:0] addr, output int unsigned n_stat);
    logic [7:0] d;
    logic [7:0] prev = 8'h00;
    int unsigned n_vbl = 0;
    n_stat = 0;
    repeat (FRAME) begin
      read_bus(addr, d);
      if (irq.vblank) begin
        n_vbl++;
        if (addr == LY_ADDR) begin
          check_value("vblank_ly", 8'(`PPU_VISIBLE_LINES), d);
          check_value("vblank_prev_ly", 8'(`PPU_VISIBLE_LINES - 1), prev);
        end
      end
      if (irq.stat) n_stat++;
      prev = d;
    end
    check_value("vblank_count", 8'd1, 8'(n_vbl));
  endtask

  // ============================================================
  // Stimulus
  // ============================================================
  initial begin
    logic [7:0]  wd;
    logic [7:0]  d;
    logic [7:0]  vd;
    logic [7:0]  od;
    logic [15:0] va;
    logic [15:0] oa;
    int unsigned n;
    logic [15:0] rw_regs [5] = '{16'hFF40, 16'hFF42, 16'hFF43, 16'hFF45, 16'hFF47};
    bus   = '0;
    reset = 1'b1;
    repeat (16) @(posedge clk);
    #1 reset = 1'b0;
    start_cyc = cyc;
    track_on  = 1'b1;
    // Timing and VBlank over two frames
    frame_pulses(STAT_ADDR, n);
    frame_pulses(LY_ADDR, n);
    // Register read-back, LCDC stays enabled
    foreach (rw_regs[i]) begin
      wd = 8'($random(seed));
      if (rw_regs[i] == LCDC_ADDR) wd[7] = 1'b1;
      write_bus(rw_regs[i], wd);
      read_bus(rw_regs[i], d);
      check_value("reg_readback", wd, d);
    end
    wd = 8'($random(seed));
    write_bus(STAT_ADDR, wd);
    read_bus(STAT_ADDR, d);
    check_value("stat_bits", {1'b0, wd[6:3], 3'b000}, {d[7:3], 3'b000});
    // LY stays on the model after a write
    write_bus(LY_ADDR, 8'($random(seed)));
    read_bus(LY_ADDR, d);
    write_bus(STAT_ADDR, 8'h00);
    // STAT requests from LYC match, then from HBlank
    write_bus(LYC_ADDR, 8'd10);
    write_bus(STAT_ADDR, 8'h40);
    repeat (3) next_cycle();
    frame_pulses(STAT_ADDR, n);
    check_value("stat_lyc_count", 8'd1, 8'(n));
    write_bus(STAT_ADDR, 8'h10);
    repeat (3) next_cycle();
    frame_pulses(STAT_ADDR, n);
    check_value("stat_hblank_count", 8'd144, 8'(n));
    write_bus(STAT_ADDR, 8'h00);
    // Memory access at the start of VBlank
    wait_for_mode(ppu_pkg::OAM_SCAN);
    wait_for_mode(ppu_pkg::VBLANK);
    repeat (8) begin
      va = `PPU_VRAM_START + {3'b000, 13'($random(seed))};
      oa = `PPU_OAM_START + 16'({$random(seed)} % `PPU_OAM_WORDS);
      vd = 8'($random(seed));
      od = 8'($random(seed));
      write_bus(va, vd);
      read_bus(va, d);
      check_value("vram_rw", vd, d);
      write_bus(oa, od);
      read_bus(oa, d);
      check_value("oam_rw", od, d);
    end
    // Blocked modes hide reads and drop writes
    wait_for_mode(ppu_pkg::OAM_SCAN);
    read_bus(oa, d);
    check_value("oam_scan_read", 8'hFF, d);
    write_bus(oa, ~od);
    wait_for_mode(ppu_pkg::TRANSFER);
    read_bus(va, d);
    check_value("vram_xfer_read", 8'hFF, d);
    read_bus(oa, d);
    check_value("oam_xfer_read", 8'hFF, d);
    write_bus(va, ~vd);
    write_bus(oa, ~od);
    wait_for_mode(ppu_pkg::HBLANK);
    read_bus(va, d);
    check_value("vram_kept", vd, d);
    read_bus(oa, d);
    check_value("oam_kept", od, d);
    // Display off, then restart from the top of the frame
    track_on = 1'b0;
    write_bus(LCDC_ADDR, 8'h11);
    read_bus(LY_ADDR, d);
    check_value("off_ly", 8'h00, d);
    read_bus(STAT_ADDR, d);
    check_value("off_mode", 8'h00, {6'd0, d[1:0]});
    write_bus(LCDC_ADDR, 8'h91);
    start_cyc = cyc;
    track_on  = 1'b1;
    frame_pulses(STAT_ADDR, n);
    frame_pulses(LY_ADDR, n);
    $display("Testbench passed");
    $finish;
  end

endmodule

//--- bench/ppu_tb_asserts.sv
`timescale 1ns/1ps

`include "ppu_settings.svh"

module ppu_tb_asserts (
  input logic                 clk,
  input logic                 reset,
  input ppu_pkg::ppu_bus_t    bus,
  input logic [7:0]           rdata,
  input ppu_pkg::ppu_irq_t    irq,
  input ppu_pkg::ppu_timing_t timing
);

  logic vram_read;

  assign vram_read = bus.read_en && (bus.addr >= `PPU_VRAM_START) &&
                     (bus.addr <= `PPU_VRAM_END);

  // No pixel transfer on VBlank lines
  no_transfer_in_vblank: assert property (@(posedge clk) disable iff (reset)
    !(timing.mode == ppu_pkg::TRANSFER && timing.ly >= 8'(`PPU_VISIBLE_LINES)))
    else $error("Pixel transfer seen on a VBlank line");

  // VBlank request lands on the first VBlank line and lasts one cycle
  vblank_one_cycle: assert property (@(posedge clk) disable iff (reset)
    irq.vblank |-> (timing.ly == 8'(`PPU_VISIBLE_LINES) &&
                    timing.mode == ppu_pkg::VBLANK) ##1 !irq.vblank)
    else $error("VBlank request outside the first VBlank line or held too long");

  stat_one_cycle: assert property (@(posedge clk) disable iff (reset)
    irq.stat |=> !irq.stat)
    else $error("STAT request high for two cycles");

  vram_blocked_read: assert property (@(posedge clk) disable iff (reset)
    (vram_read && timing.mode == ppu_pkg::TRANSFER) |-> (rdata == 8'hFF))
    else $error("VRAM read during pixel transfer returned stored data");

endmodule

bind ppu_top ppu_tb_asserts i_asserts (
  .clk    (clk),
  .reset  (reset),
  .bus    (bus),
  .rdata  (rdata),
  .irq    (irq),
  .timing (timing)
);

//--- run.sh
#!/bin/sh
# Build and run the PPU testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f src.f --top-module ppu_tb -Mdir obj_dir \
  && ./obj_dir/Vppu_tb \
  || exit 1

//--- src.f
+incdir+verilog
verilog/ppu_pkg.sv
verilog/ppu_bus_decode.sv
verilog/ppu_mode_sequencer.sv
verilog/ppu_stat_irq.sv
verilog/ppu_reg_file.sv
verilog/ppu_video_mem.sv
verilog/ppu_top.sv
bench/ppu_tb_asserts.sv
bench/ppu_tb.sv

//--- verilog/ppu_bus_decode.sv
`timescale 1ns/1ps

`include "ppu_settings.svh"

module ppu_bus_decode (
  input  ppu_pkg::ppu_bus_t bus,
  input  logic [7:0]        mem_rdata,
  input  logic [7:0]        reg_rdata,
  output logic              vram_we,
  output logic              oam_we,
  output logic              reg_we,
  output logic              mem_sel_oam,
  output logic [12:0]       offset,
  output logic [7:0]        rdata
);

  typedef enum logic [1:0] {
    REGION_NONE,
    REGION_VRAM,
    REGION_OAM,
    REGION_REGS
  } region_t;

  region_t region;

  // Classify the address once, offset is relative to the region base
  always_comb begin
    region = REGION_NONE;
    offset = '0;
    if (bus.addr inside {[`PPU_VRAM_START : `PPU_VRAM_END]}) begin
      region = REGION_VRAM;
      offset = 13'(bus.addr - `PPU_VRAM_START);
    end else if (bus.addr inside {[`PPU_OAM_START : `PPU_OAM_END]}) begin
      region = REGION_OAM;
      offset = 13'(bus.addr - `PPU_OAM_START);
    end else if (bus.addr inside {[`PPU_REGS_START : `PPU_REGS_END]}) begin
      region = REGION_REGS;
      offset = 13'(bus.addr - `PPU_REGS_START);
    end
  end

  // Exactly one write target per access
  assign vram_we     = bus.write_en && (region == REGION_VRAM);
  assign oam_we      = bus.write_en && (region == REGION_OAM);
  assign reg_we      = bus.write_en && (region == REGION_REGS);
  assign mem_sel_oam = (region == REGION_OAM);

  // Open bus reads as all ones
  always_comb begin
    rdata = 8'hFF;
    if (bus.read_en) begin
      unique case (region)
        REGION_VRAM, REGION_OAM: rdata = mem_rdata;
        REGION_REGS:             rdata = reg_rdata;
        default:                 rdata = 8'hFF;
      endcase
    end
  end

endmodule

//--- verilog/ppu_mode_sequencer.sv
`timescale 1ns/1ps

`include "ppu_settings.svh"

module ppu_mode_sequencer (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 lcd_on,
  output ppu_pkg::ppu_timing_t timing,
  output logic                 vblank_pulse
);

  logic [8:0]         dot;
  logic [7:0]         ly;
  ppu_pkg::ppu_mode_t mode;
  logic               line_end;
  logic               frame_end;
  logic               last_visible;

  assign line_end     = (dot == 9'(`PPU_CYCLES_PER_LINE - 1));
  assign frame_end    = line_end && (ly == 8'(`PPU_LINES_PER_FRAME - 1));
  assign last_visible = (ly == 8'(`PPU_VISIBLE_LINES - 1));

  // ============================================================
  // Dot and line counters
  // ============================================================
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      dot <= '0;
      ly  <= '0;
    end else if (!lcd_on) begin
      // Parked at the top of the frame while the display is off
      dot <= '0;
      ly  <= '0;
    end else if (line_end) begin
      dot <= '0;
      ly  <= frame_end ? 8'd0 : ly + 8'd1;
    end else begin
      dot <= dot + 9'd1;
    end
  end

  // ============================================================
  // Mode FSM
  // ============================================================
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      mode <= ppu_pkg::OAM_SCAN;
    end else if (!lcd_on) begin
      // Ready to restart with OAM scan
      mode <= ppu_pkg::OAM_SCAN;
    end else begin
      unique case (mode)
        ppu_pkg::OAM_SCAN: begin
          if (dot == 9'(`PPU_MODE2_LEN - 1)) mode <= ppu_pkg::TRANSFER;
        end
        ppu_pkg::TRANSFER: begin
          if (dot == 9'(`PPU_MODE2_LEN + `PPU_MODE3_LEN - 1)) mode <= ppu_pkg::HBLANK;
        end
        ppu_pkg::HBLANK: begin
          if (line_end) mode <= last_visible ? ppu_pkg::VBLANK : ppu_pkg::OAM_SCAN;
        end
        ppu_pkg::VBLANK: begin
          if (frame_end) mode <= ppu_pkg::OAM_SCAN;
        end
      endcase
    end
  end

  // High in the first cycle of line 144
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      vblank_pulse <= 1'b0;
    end else begin
      vblank_pulse <= lcd_on && line_end && last_visible;
    end
  end

  // Display off shows HBlank
  assign timing.mode = lcd_on ? mode : ppu_pkg::HBLANK;
  assign timing.ly   = ly;

endmodule

//--- verilog/ppu_pkg.sv
package ppu_pkg;

  // ============================================================
  // Display mode, encoded as the STAT mode bits
  // ============================================================
  typedef enum logic [1:0] {
    HBLANK   = 2'd0,
    VBLANK   = 2'd1,
    OAM_SCAN = 2'd2,
    TRANSFER = 2'd3
  } ppu_mode_t;

  // CPU side bus request, one cycle per access
  typedef struct packed {
    logic        read_en;
    logic        write_en;
    logic [15:0] addr;
    logic [7:0]  wdata;
  } ppu_bus_t;

  // Live display position
  typedef struct packed {
    ppu_mode_t  mode;
    logic [7:0] ly;
  } ppu_timing_t;

  // Writable register contents
  // stat_en[3] LYC match, [2] OAM scan, [1] HBlank, [0] VBlank
  typedef struct packed {
    logic [7:0] lcdc;
    logic [7:0] scy;
    logic [7:0] scx;
    logic [7:0] lyc;
    logic [7:0] bgp;
    logic [3:0] stat_en;
  } ppu_ctrl_t;

  // Interrupt request pulses
  typedef struct packed {
    logic vblank;
    logic stat;
  } ppu_irq_t;

endpackage

//--- verilog/ppu_reg_file.sv
`timescale 1ns/1ps

`include "ppu_settings.svh"

module ppu_reg_file (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 reg_we,
  input  logic [12:0]          offset,
  input  logic [7:0]           wdata,
  input  ppu_pkg::ppu_timing_t timing,
  input  logic                 coincidence,
  output ppu_pkg::ppu_ctrl_t   ctrl,
  output logic [7:0]           reg_rdata
);

  // Offsets from FF40
  localparam logic [12:0] OFS_LCDC = 13'h0;
  localparam logic [12:0] OFS_STAT = 13'h1;
  localparam logic [12:0] OFS_SCY  = 13'h2;
  localparam logic [12:0] OFS_SCX  = 13'h3;
  localparam logic [12:0] OFS_LY   = 13'h4;
  localparam logic [12:0] OFS_LYC  = 13'h5;
  localparam logic [12:0] OFS_BGP  = 13'h7;

  // ============================================================
  // Register write
  // ============================================================
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      ctrl.lcdc    <= `PPU_LCDC_RESET;
      ctrl.stat_en <= `PPU_STAT_EN_RESET;
      ctrl.scy     <= `PPU_SCROLL_RESET;
      ctrl.scx     <= `PPU_SCROLL_RESET;
      ctrl.lyc     <= `PPU_LYC_RESET;
      ctrl.bgp     <= `PPU_BGP_RESET;
    end else if (reg_we) begin
      case (offset)
        OFS_LCDC: ctrl.lcdc <= wdata;
        // Mode and match bits are status only
        OFS_STAT: ctrl.stat_en <= wdata[6:3];
        OFS_SCY:  ctrl.scy <= wdata;
        OFS_SCX:  ctrl.scx <= wdata;
        OFS_LYC:  ctrl.lyc <= wdata;
        OFS_BGP:  ctrl.bgp <= wdata;
        // LY is read only, DMA and window are not here
        default:  ;
      endcase
    end
  end

  // ============================================================
  // Register read-back
  // ============================================================
  always_comb begin
    case (offset)
      OFS_LCDC: reg_rdata = ctrl.lcdc;
      OFS_STAT: reg_rdata = {1'b0, ctrl.stat_en, coincidence, timing.mode};
      OFS_SCY:  reg_rdata = ctrl.scy;
      OFS_SCX:  reg_rdata = ctrl.scx;
      OFS_LY:   reg_rdata = timing.ly;
      OFS_LYC:  reg_rdata = ctrl.lyc;
      OFS_BGP:  reg_rdata = ctrl.bgp;
      default:  reg_rdata = 8'hFF;
    endcase
  end

endmodule

//--- verilog/ppu_settings.svh
`ifndef PPU_SETTINGS_SVH
`define PPU_SETTINGS_SVH

// ============================================================
// Display timing
// ============================================================
`define PPU_CYCLES_PER_LINE 456
`define PPU_LINES_PER_FRAME 154
`define PPU_VISIBLE_LINES   144
`define PPU_MODE2_LEN       80
`define PPU_MODE3_LEN       172

// ============================================================
// CPU address map
// ============================================================
`define PPU_VRAM_START      16'h8000
`define PPU_VRAM_END        16'h9FFF
`define PPU_OAM_START       16'hFE00
`define PPU_OAM_END         16'hFE9F
`define PPU_REGS_START      16'hFF40
`define PPU_REGS_END        16'hFF4B

// Memory depths in bytes
`define PPU_VRAM_WORDS      8192
`define PPU_OAM_WORDS       160

// Register values after reset, display enabled
`define PPU_LCDC_RESET      8'h91
`define PPU_STAT_EN_RESET   4'h0
`define PPU_SCROLL_RESET    8'h00
`define PPU_LYC_RESET       8'h00
`define PPU_BGP_RESET       8'hFC

`endif

//--- verilog/ppu_stat_irq.sv
`timescale 1ns/1ps

module ppu_stat_irq (
  input  logic                 clk,
  input  logic                 reset,
  input  ppu_pkg::ppu_timing_t timing,
  input  ppu_pkg::ppu_ctrl_t   ctrl,
  output logic                 coincidence,
  output logic                 stat_pulse
);

  logic stat_line;
  logic stat_line_q;

  assign coincidence = (timing.ly == ctrl.lyc);

  // LYC match first, then the mode sources
  always_comb begin
    stat_line = 1'b0;
    if (ctrl.stat_en[3] && coincidence) begin
      stat_line = 1'b1;
    end else if (ctrl.stat_en[2] && timing.mode == ppu_pkg::OAM_SCAN) begin
      stat_line = 1'b1;
    end else if (ctrl.stat_en[1] && timing.mode == ppu_pkg::HBLANK) begin
      stat_line = 1'b1;
    end else if (ctrl.stat_en[0] && timing.mode == ppu_pkg::VBLANK) begin
      stat_line = 1'b1;
    end
  end

  // Rising edge of the shared line gives one request
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      stat_line_q <= 1'b0;
      stat_pulse  <= 1'b0;
    end else begin
      stat_line_q <= stat_line;
      stat_pulse  <= stat_line && !stat_line_q;
    end
  end

endmodule

//--- verilog/ppu_top.sv
`timescale 1ns/1ps

module ppu_top (
  input  logic              clk,
  input  logic              reset,
  input  ppu_pkg::ppu_bus_t bus,
  output logic [7:0]        rdata,
  output ppu_pkg::ppu_irq_t irq
);

  logic                 vram_we;
  logic                 oam_we;
  logic                 reg_we;
  logic                 mem_sel_oam;
  logic [12:0]          offset;
  logic [7:0]           mem_rdata;
  logic [7:0]           reg_rdata;
  logic                 coincidence;
  ppu_pkg::ppu_ctrl_t   ctrl;
  ppu_pkg::ppu_timing_t timing;

  // ============================================================
  // CPU bus side
  // ============================================================
  ppu_bus_decode i_bus_decode (
    .bus         (bus),
    .mem_rdata   (mem_rdata),
    .reg_rdata   (reg_rdata),
    .vram_we     (vram_we),
    .oam_we      (oam_we),
    .reg_we      (reg_we),
    .mem_sel_oam (mem_sel_oam),
    .offset      (offset),
    .rdata       (rdata)
  );

  ppu_reg_file i_reg_file (
    .clk         (clk),
    .reset       (reset),
    .reg_we      (reg_we),
    .offset      (offset),
    .wdata       (bus.wdata),
    .timing      (timing),
    .coincidence (coincidence),
    .ctrl        (ctrl),
    .reg_rdata   (reg_rdata)
  );

  ppu_video_mem i_video_mem (
    .clk         (clk),
    .vram_we     (vram_we),
    .oam_we      (oam_we),
    .mem_sel_oam (mem_sel_oam),
    .offset      (offset),
    .wdata       (bus.wdata),
    .timing      (timing),
    .mem_rdata   (mem_rdata)
  );

  // ============================================================
  // Display timing and interrupts
  // ============================================================
  ppu_mode_sequencer i_mode_sequencer (
    .clk          (clk),
    .reset        (reset),
    .lcd_on       (ctrl.lcdc[7]),
    .timing       (timing),
    .vblank_pulse (irq.vblank)
  );

  ppu_stat_irq i_stat_irq (
    .clk         (clk),
    .reset       (reset),
    .timing      (timing),
    .ctrl        (ctrl),
    .coincidence (coincidence),
    .stat_pulse  (irq.stat)
  );

endmodule

//--- verilog/ppu_video_mem.sv
`timescale 1ns/1ps

`include "ppu_settings.svh"

module ppu_video_mem (
  input  logic                 clk,
  input  logic                 vram_we,
  input  logic                 oam_we,
  input  logic                 mem_sel_oam,
  input  logic [12:0]          offset,
  input  logic [7:0]           wdata,
  input  ppu_pkg::ppu_timing_t timing,
  output logic [7:0]           mem_rdata
);

  logic [7:0] vram [`PPU_VRAM_WORDS];
  logic [7:0] oam  [`PPU_OAM_WORDS];

  logic vram_open;
  logic oam_open;

  // ============================================================
  // CPU access windows
  // ============================================================
  // VRAM is busy only while pixels are pushed
  assign vram_open = (timing.mode != ppu_pkg::TRANSFER);

  // OAM is also busy during the sprite scan
  assign oam_open = (timing.mode == ppu_pkg::HBLANK) ||
                    (timing.mode == ppu_pkg::VBLANK);

  // Blocked writes are dropped
  always_ff @(posedge clk) begin
    if (vram_we && vram_open) begin
      vram[offset] <= wdata;
    end
    if (oam_we && oam_open) begin
      oam[offset[7:0]] <= wdata;
    end
  end

  // Blocked reads see open bus
  always_comb begin
    if (mem_sel_oam) begin
      mem_rdata = oam_open ? oam[offset[7:0]] : 8'hFF;
    end else begin
      mem_rdata = vram_open ? vram[offset] : 8'hFF;
    end
  end

endmodule
